/* src/decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_unit import rv_core_pkg::*; (
    input  word_t     i_instr,
    output reg_idx_t  o_rs1,
    output reg_idx_t  o_rs2,
    output reg_idx_t  o_rd,
    output word_t     o_imm,
    output alu_op_t   o_alu_op,
    output logic      o_use_imm,
    output logic      o_reg_write,
    output logic      o_is_branch,
    output logic      o_branch_ne,
    output logic      o_is_jal,
    output logic      o_is_load,
    output logic      o_is_store,
    output mem_size_t o_mem_size,
    output logic      o_is_mem,
    output logic      o_is_wfi,
    output logic      o_is_halt
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_t'(i_instr[6:0]);
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];

    assign o_rs1 = i_instr[19:15];
    assign o_rs2 = i_instr[24:20];
    assign o_rd  = i_instr[11:7];

    always_comb begin
        o_imm       = {{20{i_instr[31]}}, i_instr[31:20]};  // I format
        o_alu_op    = ALU_ADD;
        o_use_imm   = 1'b0;
        o_reg_write = 1'b0;
        o_is_branch = 1'b0;
        o_branch_ne = 1'b0;
        o_is_jal    = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_mem_size  = SIZE_WORD;
        o_is_wfi    = 1'b0;
        o_is_halt   = 1'b0;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                o_use_imm   = (opcode == OPC_OP_IMM);
                o_reg_write = 1'b1;
                case (funct3)
                    3'b000: o_alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
                    3'b001: o_alu_op = ALU_SLL;
                    3'b010: o_alu_op = ALU_SLT;
                    3'b100: o_alu_op = ALU_XOR;
                    3'b110: o_alu_op = ALU_OR;
                    3'b111: o_alu_op = ALU_AND;
                    3'b101: begin
                        o_alu_op    = ALU_SRL;
                        o_reg_write = !funct7[5];  // no sra
                    end
                    default: o_reg_write = 1'b0;  // sltu
                endcase
            end
            OPC_LUI: begin
                o_imm       = {i_instr[31:12], 12'b0};
                o_alu_op    = ALU_PASS_B;
                o_use_imm   = 1'b1;
                o_reg_write = 1'b1;
            end
            OPC_JAL: begin
                o_imm       = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                               i_instr[20], i_instr[30:21], 1'b0};
                o_is_jal    = 1'b1;
                o_reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                o_imm       = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                               i_instr[30:25], i_instr[11:8], 1'b0};
                o_is_branch = (funct3 == 3'b000) || (funct3 == 3'b001);
                o_branch_ne = funct3[0];
            end
            OPC_LOAD: begin
                o_use_imm   = 1'b1;
                o_is_load   = (funct3 == 3'b010) || (funct3 == 3'b100);
                o_reg_write = o_is_load;
                o_mem_size  = (funct3 == 3'b100) ? SIZE_BYTE : SIZE_WORD;
            end
            OPC_STORE: begin
                o_imm       = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
                o_use_imm   = 1'b1;
                o_is_store  = (funct3 == 3'b000) || (funct3 == 3'b010);
                o_mem_size  = (funct3 == 3'b000) ? SIZE_BYTE : SIZE_WORD;
            end
            OPC_SYSTEM: begin
                o_is_wfi  = (i_instr == INSTR_WFI);
                o_is_halt = (i_instr == INSTR_EBREAK);
            end
            default: ;  // no-op, pc still advances
        endcase
    end

    assign o_is_mem = o_is_load | o_is_store;

endmodule

`default_nettype wire

/* src/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit import rv_core_pkg::*; (
    input  word_t   i_pc,
    input  word_t   i_rs1_val,
    input  word_t   i_rs2_val,
    input  word_t   i_imm,
    input  alu_op_t i_alu_op,
    input  logic    i_use_imm,
    input  logic    i_is_branch,
    input  logic    i_branch_ne,
    input  logic    i_is_jal,
    output word_t   o_alu_result,
    output word_t   o_next_pc,
    output word_t   o_link
);

    word_t opb;
    logic  equal;
    logic  taken;

    assign opb = i_use_imm ? i_imm : i_rs2_val;

    always_comb begin
        case (i_alu_op)
            ALU_ADD:    o_alu_result = i_rs1_val + opb;
            ALU_SUB:    o_alu_result = i_rs1_val - opb;
            ALU_AND:    o_alu_result = i_rs1_val & opb;
            ALU_OR:     o_alu_result = i_rs1_val | opb;
            ALU_XOR:    o_alu_result = i_rs1_val ^ opb;
            ALU_SLT:    o_alu_result = {31'b0, $signed(i_rs1_val) < $signed(opb)};
            ALU_SLL:    o_alu_result = i_rs1_val << opb[4:0];
            ALU_SRL:    o_alu_result = i_rs1_val >> opb[4:0];
            ALU_PASS_B: o_alu_result = opb;
            default:    o_alu_result = '0;
        endcase
    end

    // branches compare registers, never the immediate
    assign equal = (i_rs1_val == i_rs2_val);
    assign taken = i_is_branch && (equal ^ i_branch_ne);

    assign o_link    = i_pc + 32'd4;
    assign o_next_pc = (i_is_jal || taken) ? (i_pc + i_imm) : o_link;

endmodule

`default_nettype wire

/* src/fetch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_control import rv_core_pkg::*; #(
    parameter word_t RESET_PC = 32'h80000000
) (
    input  logic  CLK,
    input  logic  i_rst_n,
    input  logic  i_i_busy,
    input  word_t i_i_rdata,
    input  word_t i_next_pc,
    input  logic  i_is_mem,
    input  logic  i_is_wfi,
    input  logic  i_is_halt,
    input  logic  i_mem_done,
    input  logic  i_ext_int,
    input  logic  i_ext_int_clear,
    input  logic  i_soft_int,
    input  logic  i_soft_int_clear,
    input  logic  i_timer_int,
    input  logic  i_timer_int_clear,
    output logic  o_i_ren,
    output word_t o_i_addr,
    output word_t o_instr,
    output word_t o_pc,
    output logic  o_mem_start,
    output logic  o_wb_en,
    output logic  o_wfi,
    output logic  o_halt
);

    typedef enum logic [2:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_WB,
        S_WAIT,
        S_HALT
    } state_t;

    state_t state;
    state_t state_d;
    word_t  pc;
    word_t  instr_q;
    word_t  next_pc_q;
    logic   ren_q;
    logic   fetch_ack;
    logic   ext_pend;
    logic   soft_pend;
    logic   timer_pend;
    logic   any_pend;

    assign any_pend  = ext_pend | soft_pend | timer_pend;
    assign fetch_ack = (state == S_FETCH) && ren_q && !i_i_busy;

    always_comb begin
        state_d = state;
        case (state)
            S_FETCH: begin
                if (fetch_ack) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                if (i_is_halt) begin
                    state_d = S_HALT;
                end else if (i_is_mem) begin
                    state_d = S_MEM;
                end else if (i_is_wfi && !any_pend) begin
                    state_d = S_WAIT;
                end else begin
                    state_d = S_WB;
                end
            end
            S_MEM: begin
                if (i_mem_done) begin
                    state_d = S_WB;
                end
            end
            S_WB:    state_d = S_FETCH;
            S_WAIT: begin
                if (any_pend) begin
                    state_d = S_WB;
                end
            end
            default: state_d = S_HALT;  // halted for good
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            state <= S_FETCH;
            ren_q <= 1'b0;
            pc    <= RESET_PC;
        end else begin
            state <= state_d;
            ren_q <= (state_d == S_FETCH);  // held until busy low
            if (state == S_WB) begin
                pc <= next_pc_q;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fetch_ack) begin
            instr_q <= i_i_rdata;
        end
        if (state == S_EXEC) begin
            next_pc_q <= i_next_pc;  // target from execute
        end
    end

    // pending latches, clear wins
    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            ext_pend   <= 1'b0;
            soft_pend  <= 1'b0;
            timer_pend <= 1'b0;
        end else begin
            ext_pend   <= i_ext_int_clear ? 1'b0 : (ext_pend | i_ext_int);
            soft_pend  <= i_soft_int_clear ? 1'b0 : (soft_pend | i_soft_int);
            timer_pend <= i_timer_int_clear ? 1'b0 : (timer_pend | i_timer_int);
        end
    end

    assign o_i_ren     = ren_q;
    assign o_i_addr    = pc;
    assign o_instr     = instr_q;
    assign o_pc        = pc;
    assign o_mem_start = (state == S_EXEC) && i_is_mem && !i_is_halt;
    assign o_wb_en     = (state == S_WB);
    assign o_wfi       = (state == S_WAIT);
    assign o_halt      = (state == S_HALT);

endmodule

`default_nettype wire

/* src/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file import rv_core_pkg::*; (
    input  logic     CLK,
    input  logic     i_rst_n,
    input  reg_idx_t i_rs1,
    input  reg_idx_t i_rs2,
    input  reg_idx_t i_rd,
    input  logic     i_we,
    input  word_t    i_wdata,
    output word_t    o_rdata1,
    output word_t    o_rdata2
);

    word_t regs [32];

    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;  // x0 stays zero
        end
    end

    assign o_rdata1 = regs[i_rs1];
    assign o_rdata2 = regs[i_rs2];

endmodule

`default_nettype wire

/* src/result_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module result_unit import rv_core_pkg::*; (
    input  logic      CLK,
    input  logic      i_rst_n,
    input  logic      i_mem_start,
    input  logic      i_is_load,
    input  logic      i_is_store,
    input  logic      i_is_jal,
    input  mem_size_t i_mem_size,
    input  word_t     i_alu_result,
    input  word_t     i_link,
    input  word_t     i_rs2_val,
    input  logic      i_d_busy,
    input  word_t     i_d_rdata,
    output logic      o_d_ren,
    output logic      o_d_wen,
    output byte_en_t  o_d_byte_en,
    output word_t     o_d_addr,
    output word_t     o_d_wdata,
    output logic      o_mem_done,
    output word_t     o_wb_data
);

    logic      ren_q;
    logic      wen_q;
    byte_en_t  byte_en_q;
    word_t     addr_q;
    word_t     wdata_q;
    mem_size_t size_q;
    logic [1:0] lane_q;
    word_t     load_q;
    word_t     lane_data;
    logic      accept;

    assign accept = (ren_q | wen_q) && !i_d_busy;

    always_ff @(posedge CLK) begin
        if (!i_rst_n) begin
            ren_q <= 1'b0;
            wen_q <= 1'b0;
        end else if (i_mem_start) begin
            ren_q <= i_is_load;
            wen_q <= i_is_store;
        end else if (accept) begin
            ren_q <= 1'b0;  // drops after busy low
            wen_q <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (i_mem_start) begin
            addr_q <= {i_alu_result[31:2], 2'b00};
            lane_q <= i_alu_result[1:0];
            size_q <= i_mem_size;
            if (i_mem_size == SIZE_WORD) begin
                byte_en_q <= 4'b1111;
                wdata_q   <= i_rs2_val;
            end else begin
                byte_en_q <= 4'b0001 << i_alu_result[1:0];
                wdata_q   <= {4{i_rs2_val[7:0]}};  // same byte on every lane
            end
        end
        if (accept && ren_q) begin
            load_q <= (size_q == SIZE_WORD) ? i_d_rdata : {24'b0, lane_data[7:0]};
        end
    end

    assign lane_data = i_d_rdata >> {lane_q, 3'b000};  // lbu lane select

    assign o_d_ren     = ren_q;
    assign o_d_wen     = wen_q;
    assign o_d_byte_en = byte_en_q;
    assign o_d_addr    = addr_q;
    assign o_d_wdata   = wdata_q;
    assign o_mem_done  = accept;

    always_comb begin
        if (i_is_load) begin
            o_wb_data = load_q;
        end else if (i_is_jal) begin
            o_wb_data = i_link;
        end else begin
            o_wb_data = i_alu_result;
        end
    end

endmodule

`default_nettype wire

/* src/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  byte_en_t;

    // major opcodes in use
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // lui
    } alu_op_t;

    typedef enum logic {
        SIZE_BYTE,
        SIZE_WORD
    } mem_size_t;

    // full system encodings
    localparam word_t INSTR_WFI    = 32'h10500073;
    localparam word_t INSTR_EBREAK = 32'h00100073;

endpackage

`default_nettype wire

/* src/top_core.sv */
`timescale 1ns/1ps
`default_nettype none

module top_core import rv_core_pkg::*; #(
    parameter word_t RESET_PC = 32'h80000000
) (
    input  logic     CLK,
    input  logic     i_rst_n,
    output logic     o_wfi,
    output logic     o_halt,
    input  logic     i_i_busy,
    input  word_t    i_i_rdata,
    output logic     o_i_ren,
    output logic     o_i_wen,
    output byte_en_t o_i_byte_en,
    output word_t    o_i_addr,
    output word_t    o_i_wdata,
    input  logic     i_d_busy,
    input  word_t    i_d_rdata,
    output logic     o_d_ren,
    output logic     o_d_wen,
    output byte_en_t o_d_byte_en,
    output word_t    o_d_addr,
    output word_t    o_d_wdata,
    input  logic     i_ext_int,
    input  logic     i_ext_int_clear,
    input  logic     i_soft_int,
    input  logic     i_soft_int_clear,
    input  logic     i_timer_int,
    input  logic     i_timer_int_clear
);

    word_t     instr;
    word_t     pc;
    word_t     next_pc;
    word_t     link;
    word_t     imm;
    word_t     alu_result;
    word_t     wb_data;
    word_t     rs1_val;
    word_t     rs2_val;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    alu_op_t   alu_op;
    mem_size_t mem_size;
    logic      use_imm;
    logic      reg_write;
    logic      is_branch;
    logic      branch_ne;
    logic      is_jal;
    logic      is_load;
    logic      is_store;
    logic      is_mem;
    logic      is_wfi;
    logic      is_halt;
    logic      mem_start;
    logic      mem_done;
    logic      wb_en;

    // instruction bus is read only
    assign o_i_wen     = 1'b0;
    assign o_i_byte_en = 4'b1111;
    assign o_i_wdata   = '0;

    fetch_control #(.RESET_PC(RESET_PC)) u_fetch (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_i_busy(i_i_busy), .i_i_rdata(i_i_rdata),
        .i_next_pc(next_pc), .i_is_mem(is_mem), .i_is_wfi(is_wfi), .i_is_halt(is_halt),
        .i_mem_done(mem_done), .i_ext_int(i_ext_int), .i_ext_int_clear(i_ext_int_clear),
        .i_soft_int(i_soft_int), .i_soft_int_clear(i_soft_int_clear),
        .i_timer_int(i_timer_int), .i_timer_int_clear(i_timer_int_clear),
        .o_i_ren(o_i_ren), .o_i_addr(o_i_addr), .o_instr(instr), .o_pc(pc),
        .o_mem_start(mem_start), .o_wb_en(wb_en), .o_wfi(o_wfi), .o_halt(o_halt)
    );

    decode_unit u_decode (
        .i_instr(instr), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
        .o_alu_op(alu_op), .o_use_imm(use_imm), .o_reg_write(reg_write),
        .o_is_branch(is_branch), .o_branch_ne(branch_ne), .o_is_jal(is_jal),
        .o_is_load(is_load), .o_is_store(is_store), .o_mem_size(mem_size),
        .o_is_mem(is_mem), .o_is_wfi(is_wfi), .o_is_halt(is_halt)
    );

    register_file u_regs (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
        .i_we(wb_en && reg_write), .i_wdata(wb_data),
        .o_rdata1(rs1_val), .o_rdata2(rs2_val)
    );

    execute_unit u_exec (
        .i_pc(pc), .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .i_imm(imm),
        .i_alu_op(alu_op), .i_use_imm(use_imm), .i_is_branch(is_branch),
        .i_branch_ne(branch_ne), .i_is_jal(is_jal),
        .o_alu_result(alu_result), .o_next_pc(next_pc), .o_link(link)
    );

    result_unit u_result (
        .CLK(CLK), .i_rst_n(i_rst_n), .i_mem_start(mem_start), .i_is_load(is_load),
        .i_is_store(is_store), .i_is_jal(is_jal), .i_mem_size(mem_size),
        .i_alu_result(alu_result), .i_link(link), .i_rs2_val(rs2_val),
        .i_d_busy(i_d_busy), .i_d_rdata(i_d_rdata),
        .o_d_ren(o_d_ren), .o_d_wen(o_d_wen), .o_d_byte_en(o_d_byte_en),
        .o_d_addr(o_d_addr), .o_d_wdata(o_d_wdata),
        .o_mem_done(mem_done), .o_wb_data(wb_data)
    );

endmodule

`default_nettype wire

/* top_core.f */
src/rv_core_pkg.sv
src/fetch_control.sv
src/decode_unit.sv
src/register_file.sv
src/execute_unit.sv
src/result_unit.sv
src/top_core.sv
verification/tb_clock_gen.sv
verification/top_core_tb.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #50 o_clk = ~o_clk;  // 100 ns period
        end
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verification/top_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module top_core_tb import rv_core_pkg::*; ();

    localparam word_t RESET_PC       = 32'h80000000;
    localparam int    PROG_LEN       = 46;
    localparam int    N_STORES       = 18;
    localparam int    WAKE_IDX       = 16;  // first store after the timer wake
    localparam int    MEM_WORDS      = 256;
    localparam int    TIMEOUT_CYCLES = PROG_LEN * 40;

    logic     CLK;
    logic     rst_n;
    logic     o_wfi;
    logic     o_halt;
    logic     i_i_busy;
    word_t    i_i_rdata;
    logic     o_i_ren;
    logic     o_i_wen;
    byte_en_t o_i_byte_en;
    word_t    o_i_addr;
    word_t    o_i_wdata;
    logic     i_d_busy;
    word_t    i_d_rdata;
    logic     o_d_ren;
    logic     o_d_wen;
    byte_en_t o_d_byte_en;
    word_t    o_d_addr;
    word_t    o_d_wdata;
    logic     i_ext_int;
    logic     i_ext_int_clear;
    logic     i_soft_int;
    logic     i_soft_int_clear;
    logic     i_timer_int;
    logic     i_timer_int_clear;

    word_t prog [PROG_LEN] = '{
        32'h800000B7,  // lui  x1, 0x80000
        32'h01900113,  // addi x2, x0, 25
        32'hFF900193,  // addi x3, x0, -7
        32'h00310233,  // add  x4, x2, x3
        32'h2040A023,  // sw   x4, 0x200(x1)
        32'h403102B3,  // sub  x5, x2, x3
        32'h2050A223,  // sw   x5, 0x204(x1)
        32'h0021A333,  // slt  x6, x3, x2
        32'h2060A423,  // sw   x6, 0x208(x1)
        32'h00411393,  // slli x7, x2, 4
        32'h0061D433,  // srl  x8, x3, x6
        32'h2080A623,  // sw   x8, 0x20c(x1)
        32'h0033C4B3,  // xor  x9, x7, x3
        32'h2090A823,  // sw   x9, 0x210(x1)
        32'h00526533,  // or   x10, x4, x5
        32'h50056613,  // ori  x12, x10, 0x500
        32'h009676B3,  // and  x13, x12, x9
        32'h20D0AA23,  // sw   x13, 0x214(x1)
        32'h01C4D713,  // srli x14, x9, 28
        32'h0F04F793,  // andi x15, x9, 0xf0
        32'h00E79833,  // sll  x16, x15, x14
        32'h2100AC23,  // sw   x16, 0x218(x1)
        32'h1A500893,  // addi x17, x0, 0x1a5
        32'h03C00913,  // addi x18, x0, 0x3c
        32'h23108023,  // sb   x17, 0x220(x1)
        32'h232080A3,  // sb   x18, 0x221(x1)
        32'h23108123,  // sb   x17, 0x222(x1)
        32'h232081A3,  // sb   x18, 0x223(x1)
        32'h2210C983,  // lbu  x19, 0x221(x1)
        32'h2130AE23,  // sw   x19, 0x21c(x1)
        32'h2220CA03,  // lbu  x20, 0x222(x1)
        32'h2340A223,  // sw   x20, 0x224(x1)
        32'h2200AA83,  // lw   x21, 0x220(x1)
        32'h2350A423,  // sw   x21, 0x228(x1)
        32'h00210463,  // beq  x2, x2, +8
        32'h2220A623,  // sw   x2, 0x22c(x1)  skipped
        32'h00211463,  // bne  x2, x2, +8
        32'h2230A623,  // sw   x3, 0x22c(x1)
        32'h00800B6F,  // jal  x22, +8
        32'h2220A823,  // sw   x2, 0x230(x1)  skipped
        32'h2360A823,  // sw   x22, 0x230(x1)
        32'h10500073,  // wfi, waits for timer
        32'h2240AA23,  // sw   x4, 0x234(x1)
        32'h10500073,  // wfi, ext already pending
        32'h2250AC23,  // sw   x5, 0x238(x1)
        32'h00100073   // ebreak
    };

    // address, data, byte enables
    logic [67:0] exp_tab [N_STORES] = '{
        {32'h80000200, 32'h00000012, 4'b1111},
        {32'h80000204, 32'h00000020, 4'b1111},
        {32'h80000208, 32'h00000001, 4'b1111},
        {32'h8000020C, 32'h7FFFFFFC, 4'b1111},
        {32'h80000210, 32'hFFFFFE69, 4'b1111},
        {32'h80000214, 32'h00000420, 4'b1111},
        {32'h80000218, 32'h00300000, 4'b1111},
        {32'h80000220, 32'hA5A5A5A5, 4'b0001},
        {32'h80000220, 32'h3C3C3C3C, 4'b0010},
        {32'h80000220, 32'hA5A5A5A5, 4'b0100},
        {32'h80000220, 32'h3C3C3C3C, 4'b1000},
        {32'h8000021C, 32'h0000003C, 4'b1111},
        {32'h80000224, 32'h000000A5, 4'b1111},
        {32'h80000228, 32'h3CA53CA5, 4'b1111},
        {32'h8000022C, 32'hFFFFFFF9, 4'b1111},
        {32'h80000230, 32'h8000009C, 4'b1111},
        {32'h80000234, 32'h00000012, 4'b1111},
        {32'h80000238, 32'h00000020, 4'b1111}
    };

    word_t mem [MEM_WORDS];
    word_t lfsr             = 32'hb6d30b3e;
    int    i_wait           = 0;
    int    d_wait           = 0;
    int    wfi_cycles       = 0;
    int    store_idx        = 0;
    logic  i_active         = 1'b0;
    logic  d_active         = 1'b0;
    logic  first_fetch_seen = 1'b0;
    logic  wfi_seen         = 1'b0;
    logic  timer_raised     = 1'b0;
    logic  ext_raised       = 1'b0;

    tb_clock_gen u_clk (
        .o_clk(CLK),
        .o_rst_n(rst_n)
    );

    top_core #(.RESET_PC(RESET_PC)) UUT (
        .CLK(CLK), .i_rst_n(rst_n), .o_wfi(o_wfi), .o_halt(o_halt),
        .i_i_busy(i_i_busy), .i_i_rdata(i_i_rdata), .o_i_ren(o_i_ren),
        .o_i_wen(o_i_wen), .o_i_byte_en(o_i_byte_en), .o_i_addr(o_i_addr),
        .o_i_wdata(o_i_wdata), .i_d_busy(i_d_busy), .i_d_rdata(i_d_rdata),
        .o_d_ren(o_d_ren), .o_d_wen(o_d_wen), .o_d_byte_en(o_d_byte_en),
        .o_d_addr(o_d_addr), .o_d_wdata(o_d_wdata),
        .i_ext_int(i_ext_int), .i_ext_int_clear(i_ext_int_clear),
        .i_soft_int(i_soft_int), .i_soft_int_clear(i_soft_int_clear),
        .i_timer_int(i_timer_int), .i_timer_int_clear(i_timer_int_clear)
    );

    function automatic word_t lfsr_step(input word_t s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    // busy length 0 to 3, one lfsr step per bit
    task automatic draw_delay(output int d);
        int b;
        d = 0;
        for (b = 0; b < 2; b++) begin
            lfsr = lfsr_step(lfsr);
            d = (d << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic stop_on_error();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string msg);
        $display("%0t ns: %s", $time, msg);
        stop_on_error();
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_byte_en(input byte_en_t got, input byte_en_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_in_range(input word_t a, input string bus);
        if (a[31:10] != RESET_PC[31:10]) begin
            report_problem($sformatf("%s bus address %h lies outside the memory", bus, a));
        end
    endtask

    task automatic accept_store();
        logic [67:0] e;
        int          k;
        if (store_idx >= N_STORES) begin
            report_problem($sformatf("unexpected extra store to %h", o_d_addr));
        end
        if (store_idx >= WAKE_IDX && !timer_raised) begin
            report_problem("store after WFI happened before any interrupt was raised");
        end
        e = exp_tab[store_idx];
        check_word(o_d_addr, e[67:36], $sformatf("store %0d address", store_idx));
        check_word(o_d_wdata, e[35:4], $sformatf("store %0d data", store_idx));
        check_byte_en(o_d_byte_en, e[3:0], $sformatf("store %0d byte_en", store_idx));
        for (k = 0; k < 4; k++) begin
            if (o_d_byte_en[k]) begin
                mem[o_d_addr[9:2]][8*k +: 8] = o_d_wdata[8*k +: 8];
            end
        end
        store_idx++;
    endtask

    // memory model, checks and interrupt driver, all on the falling edge
    always @(negedge CLK) begin
        if (!rst_n) begin
            if (o_i_ren !== 1'b0 || o_d_ren !== 1'b0 || o_d_wen !== 1'b0) begin
                report_problem("a bus request was high during reset");
            end
        end else begin
            if (o_halt && (o_i_ren || o_d_ren || o_d_wen)) begin
                report_problem("a bus request appeared after the core halted");
            end
            if (o_i_wen !== 1'b0) begin
                report_problem("the instruction bus requested a write");
            end
            if (o_i_ren) begin
                if (!i_active) begin
                    i_active = 1'b1;
                    draw_delay(i_wait);
                    check_in_range(o_i_addr, "instruction");
                    check_byte_en(o_i_byte_en, 4'b1111, "instruction byte_en");
                    check_word(o_i_wdata, 32'h00000000, "instruction wdata");
                    if (!first_fetch_seen) begin
                        first_fetch_seen = 1'b1;
                        check_word(o_i_addr, RESET_PC, "first fetch address");
                    end
                end
                if (i_wait > 0) begin
                    i_i_busy = 1'b1;
                    i_wait--;
                end else begin
                    i_i_busy  = 1'b0;
                    i_i_rdata = mem[o_i_addr[9:2]];
                end
            end else begin
                i_active = 1'b0;
                i_i_busy = 1'b0;
            end
            if (o_d_ren || o_d_wen) begin
                if (!d_active) begin
                    d_active = 1'b1;
                    draw_delay(d_wait);
                    check_in_range(o_d_addr, "data");
                end
                if (d_wait > 0) begin
                    i_d_busy = 1'b1;
                    d_wait--;
                end else begin
                    i_d_busy = 1'b0;
                    if (o_d_wen) begin
                        accept_store();
                    end else begin
                        i_d_rdata = mem[o_d_addr[9:2]];
                    end
                end
            end else begin
                d_active = 1'b0;
                i_d_busy = 1'b0;
            end
            if (o_wfi) begin
                if (!wfi_seen) begin
                    wfi_seen = 1'b1;
                    if (store_idx != WAKE_IDX) begin
                        report_problem("core reached WFI before the earlier stores finished");
                    end
                end
                if (ext_raised) begin
                    report_problem("core stalled in WFI with the external interrupt pending");
                end
                if (o_i_ren) begin
                    report_problem("instruction fetch while the core waits for an interrupt");
                end
                wfi_cycles++;
                if (wfi_cycles == 4) begin
                    i_timer_int  = 1'b1;
                    timer_raised = 1'b1;
                end
            end else if (timer_raised && !ext_raised) begin
                i_timer_int       = 1'b0;
                i_timer_int_clear = 1'b1;  // drop the timer latch
                i_ext_int         = 1'b1;  // left pending for the second wfi
                ext_raised        = 1'b1;
            end else begin
                i_timer_int_clear = 1'b0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge CLK);
        report_problem($sformatf("timeout, the core did not halt within %0d cycles",
                                 TIMEOUT_CYCLES));
    end

    initial begin
        word_t a;
        int    k;
        i_i_busy          = 1'b0;
        i_i_rdata         = '0;
        i_d_busy          = 1'b0;
        i_d_rdata         = '0;
        i_ext_int         = 1'b0;
        i_ext_int_clear   = 1'b0;
        i_soft_int        = 1'b0;
        i_soft_int_clear  = 1'b0;
        i_timer_int       = 1'b0;
        i_timer_int_clear = 1'b0;
        for (k = 0; k < MEM_WORDS; k++) begin
            a      = RESET_PC + 32'(4 * k);
            mem[k] = ~a ^ {a[15:0], a[31:16]};  // fill from the byte address
        end
        for (k = 0; k < PROG_LEN; k++) begin
            mem[k] = prog[k];
        end
        while (o_halt !== 1'b1) @(negedge CLK);
        repeat (10) @(negedge CLK);  // watch for requests after halt
        @(posedge CLK);
        if (store_idx != N_STORES) begin
            report_problem($sformatf("core halted after %0d of %0d expected stores",
                                     store_idx, N_STORES));
        end else begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
